// ==== compile.f ====
+incdir+design
design/tinker_pkg.sv
design/tinker_register_file.sv
design/tinker_fetch.sv
design/tinker_decode.sv
design/tinker_execute.sv
design/tinker_writeback.sv
design/tinker_core.sv
tb/tinker_core_tb.sv

// ==== design/tinker_config.svh ====
// ########################################
// Build parameters for the tinker core
// Memory depths must be powers of two
// ########################################
`ifndef TINKER_CONFIG_SVH
`define TINKER_CONFIG_SVH

// Data path and address width
`define TINKER_XLEN       64
`define TINKER_INSTR_W    32
`define TINKER_REG_COUNT  32

// Instruction memory in 32-bit words, data memory in 64-bit words
`define TINKER_IMEM_WORDS 4096
`define TINKER_DMEM_WORDS 1024

`define TINKER_RESET_PC   64'h2000

`endif

// ==== design/tinker_core.sv ====
// ########################################
// Four-stage tinker core, top level
// Load the program while reset is high
// ########################################
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_core
    import tinker_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load_en,
    input  logic [$clog2(`TINKER_IMEM_WORDS)-1:0] load_addr,
    input  logic [`TINKER_INSTR_W-1:0]            load_data,
    output logic                                  wb_valid,
    output reg_addr_t                             wb_addr,
    output logic [`TINKER_XLEN-1:0]               wb_data,
    output logic                                  hlt
);

    // Fetch and redirect
    logic [`TINKER_XLEN-1:0]    pc_de;
    logic [`TINKER_INSTR_W-1:0] instr_de;
    logic                       stall;
    logic                       branch_taken;
    logic [`TINKER_XLEN-1:0]    branch_pc;
    logic                       halted;

    // Decode/execute register
    logic [`TINKER_XLEN-1:0]    pc_ex, op_a, op_b, op_c, literal_ex;
    reg_addr_t                  rd_ex;
    opcode_t                    opcode_ex;
    logic                       reg_write_ex, mem_read_ex, mem_write_ex;
    logic [`TINKER_XLEN-1:0]    ex_result;

    // Execute/memory register
    logic [`TINKER_XLEN-1:0]    result_mem, addr_mem, store_data_mem;
    reg_addr_t                  rd_mem;
    logic                       reg_write_mem, mem_read_mem, mem_write_mem, halt_req_mem;

    tinker_fetch i_fetch (.*);

    tinker_decode i_decode (
        .*,
        .ex_rd        (rd_ex),
        .ex_reg_write (reg_write_ex),
        .ex_mem_read  (mem_read_ex)
    );

    tinker_execute i_execute (.*);

    tinker_writeback i_writeback (.*);

endmodule

// ==== design/tinker_decode.sv ====
// ########################################
// Decode, forwarding, load-use stall
// Forwarding prefers execute over write-back
// A taken branch overrides the stall
// ########################################
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_decode
    import tinker_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`TINKER_XLEN-1:0]    pc_de,
    input  logic [`TINKER_INSTR_W-1:0] instr_de,
    input  logic                       branch_taken,
    input  reg_addr_t                  ex_rd,
    input  logic                       ex_reg_write,
    input  logic                       ex_mem_read,
    input  logic [`TINKER_XLEN-1:0]    ex_result,
    input  logic                       wb_valid,
    input  reg_addr_t                  wb_addr,
    input  logic [`TINKER_XLEN-1:0]    wb_data,
    output logic                       stall,
    output logic [`TINKER_XLEN-1:0]    pc_ex,
    output logic [`TINKER_XLEN-1:0]    op_a,
    output logic [`TINKER_XLEN-1:0]    op_b,
    output logic [`TINKER_XLEN-1:0]    op_c,
    output logic [`TINKER_XLEN-1:0]    literal_ex,
    output reg_addr_t                  rd_ex,
    output opcode_t                    opcode_ex,
    output logic                       reg_write_ex,
    output logic                       mem_read_ex,
    output logic                       mem_write_ex
);

    opcode_t                 opcode;
    reg_addr_t               rd, rs, rt;
    logic [`TINKER_XLEN-1:0] literal;
    logic [`TINKER_XLEN-1:0] rf_a, rf_b, rf_c;
    logic [`TINKER_XLEN-1:0] fwd_a, fwd_b, fwd_c;
    logic                    reg_write, mem_read, mem_write, use_lit, uses_c;
    fwd_sel_t                sel_a, sel_b, sel_c;

    tinker_register_file i_regs (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wb_valid),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .rd_addr_a (rs),
        .rd_addr_b (rt),
        .rd_addr_c (rd),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .rd_data_c (rf_c)
    );

    // ########################################
    // Fields and control
    // ########################################
    always_comb begin
        opcode    = opcode_t'(instr_de[31:27]);
        rd        = instr_de[26:22];
        rs        = instr_de[21:17];
        rt        = instr_de[16:12];
        literal   = {{(`TINKER_XLEN-12){instr_de[11]}}, instr_de[11:0]};
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_lit   = 1'b0;
        uses_c    = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTL, OP_MOV_REG: begin
                reg_write = 1'b1;
            end
            // Immediate forms read and write rd
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOV_LIT: begin
                reg_write = 1'b1;
                use_lit   = 1'b1;
                rs        = rd;
            end
            OP_MOV_MEM: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                use_lit   = 1'b1;
            end
            OP_MOV_STR: begin
                mem_write = 1'b1;
                uses_c    = 1'b1;
            end
            OP_BR, OP_BRR, OP_BRNZ, OP_BRGT: begin
                uses_c = 1'b1;
            end
            OP_BRRI: begin
                use_lit = 1'b1;
            end
            default: ;
        endcase
    end

    function automatic fwd_sel_t fwd_source(input reg_addr_t addr);
        if (ex_reg_write && ex_rd == addr) begin
            return FWD_EX;
        end else if (wb_valid && wb_addr == addr) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    function automatic logic [`TINKER_XLEN-1:0] fwd_pick(input fwd_sel_t sel,
                                                         input logic [`TINKER_XLEN-1:0] rf);
        case (sel)
            FWD_EX:  return ex_result;
            FWD_WB:  return wb_data;
            default: return rf;
        endcase
    endfunction

    always_comb begin
        sel_a = fwd_source(rs);
        sel_b = fwd_source(rt);
        sel_c = fwd_source(rd);
        fwd_a = fwd_pick(sel_a, rf_a);
        fwd_b = fwd_pick(sel_b, rf_b);
        fwd_c = fwd_pick(sel_c, rf_c);
    end

    // Load data is ready one stage later, so wait a cycle
    assign stall = ex_mem_read &&
                   (ex_rd == rs || ex_rd == rt || (uses_c && ex_rd == rd));

    // ########################################
    // Decode/execute register
    // ########################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset || stall || branch_taken) begin
            opcode_ex    <= OP_AND;
            reg_write_ex <= 1'b0;
            mem_read_ex  <= 1'b0;
            mem_write_ex <= 1'b0;
        end else begin
            opcode_ex    <= opcode;
            reg_write_ex <= reg_write;
            mem_read_ex  <= mem_read;
            mem_write_ex <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        pc_ex      <= pc_de;
        op_a       <= fwd_a;
        op_b       <= use_lit ? literal : fwd_b;
        op_c       <= fwd_c;
        literal_ex <= literal;
        rd_ex      <= rd;
    end

    // The flush must replace the held instruction, not keep it
    a_flush_over_stall: assert property (@(posedge clk) disable iff (reset)
        stall && branch_taken |=> instr_de == NOP_INSTR)
        else $error("stall held an instruction through a flush");

endmodule

// ==== design/tinker_execute.sv ====
// ########################################
// ALU, branch resolution, execute/memory register
// Branches resolve from the registered outputs
// ########################################
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_execute
    import tinker_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`TINKER_XLEN-1:0] pc_ex,
    input  logic [`TINKER_XLEN-1:0] op_a,
    input  logic [`TINKER_XLEN-1:0] op_b,
    input  logic [`TINKER_XLEN-1:0] op_c,
    input  logic [`TINKER_XLEN-1:0] literal_ex,
    input  reg_addr_t               rd_ex,
    input  opcode_t                 opcode_ex,
    input  logic                    reg_write_ex,
    input  logic                    mem_read_ex,
    input  logic                    mem_write_ex,
    output logic [`TINKER_XLEN-1:0] ex_result,
    output logic [`TINKER_XLEN-1:0] result_mem,
    output logic [`TINKER_XLEN-1:0] addr_mem,
    output logic [`TINKER_XLEN-1:0] store_data_mem,
    output reg_addr_t               rd_mem,
    output logic                    reg_write_mem,
    output logic                    mem_read_mem,
    output logic                    mem_write_mem,
    output logic                    halt_req_mem,
    output logic                    branch_taken,
    output logic [`TINKER_XLEN-1:0] branch_pc
);

    logic [`TINKER_XLEN-1:0] result, addr, target;
    logic                    taken, halt_req;

    always_comb begin
        result = '0;
        addr   = '0;
        target = op_c;
        taken  = 1'b0;
        case (opcode_ex)
            OP_ADD, OP_ADDI:     result = op_a + op_b;
            OP_SUB, OP_SUBI:     result = op_a - op_b;
            OP_AND:              result = op_a & op_b;
            OP_OR:               result = op_a | op_b;
            OP_XOR:              result = op_a ^ op_b;
            OP_NOT:              result = ~op_a;
            OP_SHFTR, OP_SHFTRI: result = $signed(op_a) >>> op_b[5:0];
            OP_SHFTL, OP_SHFTLI: result = op_a << op_b[5:0];
            OP_MOV_REG:          result = op_a;
            OP_MOV_LIT:          result = {op_a[`TINKER_XLEN-1:12], literal_ex[11:0]};
            OP_MOV_MEM:          addr   = op_a + op_b;
            OP_MOV_STR:          addr   = op_c + literal_ex;
            OP_BR:               taken  = 1'b1;
            OP_BRR: begin
                taken  = 1'b1;
                target = pc_ex + op_c;
            end
            OP_BRRI: begin
                taken  = 1'b1;
                target = pc_ex + op_b;
            end
            OP_BRNZ:             taken  = (op_a != '0);
            OP_BRGT:             taken  = ($signed(op_a) > $signed(op_b));
            default: ;
        endcase
    end

    // Only PRIV 0 halts
    assign halt_req  = (opcode_ex == OP_PRIV) && (literal_ex[11:0] == 12'h000);
    assign ex_result = result;

    // ########################################
    // Execute/memory register
    // ########################################
    // A taken branch squashes the instruction behind it
    always_ff @(posedge clk or posedge reset) begin
        if (reset || branch_taken) begin
            reg_write_mem <= 1'b0;
            mem_read_mem  <= 1'b0;
            mem_write_mem <= 1'b0;
            halt_req_mem  <= 1'b0;
            branch_taken  <= 1'b0;
        end else begin
            reg_write_mem <= reg_write_ex;
            mem_read_mem  <= mem_read_ex;
            mem_write_mem <= mem_write_ex;
            halt_req_mem  <= halt_req;
            branch_taken  <= taken;
        end
    end

    always_ff @(posedge clk) begin
        result_mem     <= result;
        addr_mem       <= addr;
        store_data_mem <= op_a;
        rd_mem         <= rd_ex;
        branch_pc      <= target;
    end

    a_taken_is_branch: assert property (@(posedge clk) disable iff (reset)
        branch_taken |-> $past(opcode_ex) inside {OP_BR, OP_BRR, OP_BRRI, OP_BRNZ, OP_BRGT})
        else $error("redirect from a non-branch opcode");

endmodule

// ==== design/tinker_fetch.sv ====
// ########################################
// PC, instruction memory and fetch/decode register
// The load port is only for use while reset is high
// ########################################
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_fetch
    import tinker_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load_en,
    input  logic [$clog2(`TINKER_IMEM_WORDS)-1:0] load_addr,
    input  logic [`TINKER_INSTR_W-1:0]            load_data,
    input  logic                                  stall,
    input  logic                                  branch_taken,
    input  logic [`TINKER_XLEN-1:0]               branch_pc,
    input  logic                                  halted,
    output logic [`TINKER_XLEN-1:0]               pc_de,
    output logic [`TINKER_INSTR_W-1:0]            instr_de
);

    localparam int IMEM_AW = $clog2(`TINKER_IMEM_WORDS);

    logic [`TINKER_INSTR_W-1:0] imem [`TINKER_IMEM_WORDS];
    logic [`TINKER_XLEN-1:0]    pc;
    logic [`TINKER_XLEN-1:0]    pc_offset;
    logic [`TINKER_INSTR_W-1:0] instr_if;

    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    // Word index counts from the reset PC
    assign pc_offset = pc - `TINKER_RESET_PC;
    assign instr_if  = imem[pc_offset[2 +: IMEM_AW]];

    // Redirect wins over a stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `TINKER_RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_pc;
        end else if (!(stall || halted)) begin
            pc <= pc + 64'd4;
        end
    end

    // ########################################
    // Fetch/decode register
    // ########################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_de <= NOP_INSTR;
        end else if (branch_taken || halted) begin
            instr_de <= NOP_INSTR;
        end else if (!stall) begin
            instr_de <= instr_if;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_de <= pc;
        end
    end

    a_load_in_reset: assert property (@(posedge clk) load_en |-> reset)
        else $error("instruction load outside reset");

endmodule

// ==== design/tinker_pkg.sv ====
// ########################################
// Shared types of the tinker core
// Opcodes outside opcode_t decode as no-ops
// ########################################
package tinker_pkg;

    typedef enum logic [4:0] {
        OP_AND     = 5'h00,
        OP_OR      = 5'h01,
        OP_XOR     = 5'h02,
        OP_NOT     = 5'h03,
        OP_SHFTR   = 5'h04,
        OP_SHFTRI  = 5'h05,
        OP_SHFTL   = 5'h06,
        OP_SHFTLI  = 5'h07,
        OP_BR      = 5'h08,
        OP_BRR     = 5'h09,
        OP_BRRI    = 5'h0a,
        OP_BRNZ    = 5'h0b,
        OP_BRGT    = 5'h0e,
        OP_PRIV    = 5'h0f,
        OP_MOV_MEM = 5'h10,
        OP_MOV_REG = 5'h11,
        OP_MOV_LIT = 5'h12,
        OP_MOV_STR = 5'h13,
        OP_ADD     = 5'h18,
        OP_ADDI    = 5'h19,
        OP_SUB     = 5'h1a,
        OP_SUBI    = 5'h1b
    } opcode_t;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_EX = 2'd1,
        FWD_WB = 2'd2
    } fwd_sel_t;

    // PRIV with a nonzero literal does nothing, so it serves as the pipeline NOP
    localparam logic [31:0] NOP_INSTR = {OP_PRIV, 27'd1};

endpackage

// ==== design/tinker_register_file.sv ====
// ########################################
// 32 x 64 register file, R0 is ordinary
// Reads see a write made in the same cycle
// ########################################
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_register_file
    import tinker_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  reg_addr_t               wr_addr,
    input  logic [`TINKER_XLEN-1:0] wr_data,
    input  reg_addr_t               rd_addr_a,
    input  reg_addr_t               rd_addr_b,
    input  reg_addr_t               rd_addr_c,
    output logic [`TINKER_XLEN-1:0] rd_data_a,
    output logic [`TINKER_XLEN-1:0] rd_data_b,
    output logic [`TINKER_XLEN-1:0] rd_data_c
);

    logic [`TINKER_XLEN-1:0] regs [`TINKER_REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];
    assign rd_data_c = (wr_en && wr_addr == rd_addr_c) ? wr_data : regs[rd_addr_c];

endmodule

// ==== design/tinker_writeback.sv ====
// ########################################
// Data memory, write-back select, halt latch
// Loads read combinationally, stores write at the edge
// Nothing writes after halt until reset
// ########################################
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_writeback
    import tinker_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`TINKER_XLEN-1:0] result_mem,
    input  logic [`TINKER_XLEN-1:0] addr_mem,
    input  logic [`TINKER_XLEN-1:0] store_data_mem,
    input  reg_addr_t               rd_mem,
    input  logic                    reg_write_mem,
    input  logic                    mem_read_mem,
    input  logic                    mem_write_mem,
    input  logic                    halt_req_mem,
    output logic                    wb_valid,
    output reg_addr_t               wb_addr,
    output logic [`TINKER_XLEN-1:0] wb_data,
    output logic                    halted,
    output logic                    hlt
);

    localparam int DMEM_AW = $clog2(`TINKER_DMEM_WORDS);

    logic [`TINKER_XLEN-1:0] dmem [`TINKER_DMEM_WORDS];
    logic [DMEM_AW-1:0]      dmem_idx;

    // 64-bit words, byte offset bits ignored
    assign dmem_idx = addr_mem[3 +: DMEM_AW];

    always_ff @(posedge clk) begin
        if (mem_write_mem && !hlt) begin
            dmem[dmem_idx] <= store_data_mem;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hlt <= 1'b0;
        end else if (halt_req_mem) begin
            hlt <= 1'b1;
        end
    end

    assign halted   = hlt;
    assign wb_valid = reg_write_mem && !hlt;
    assign wb_addr  = rd_mem;
    assign wb_data  = mem_read_mem ? dmem[dmem_idx] : result_mem;

    a_read_write_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_read_mem && mem_write_mem))
        else $error("load and store in the same slot");

endmodule

// ==== tb/tinker_core_tb.sv ====
// ########################################
// Directed tests for the tinker core
// Expected writes come from an ISA-level model of each program
// Data memory is not reset, so each test stores before it loads
// ########################################
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_core_tb
    import tinker_pkg::*;
();

    localparam int IMEM_AW         = $clog2(`TINKER_IMEM_WORDS);
    localparam int PROG_WORDS      = 40;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int CYCLE_LIMIT     = CYCLES_PER_TEST * NUM_TESTS;

    logic                       clk;
    logic                       reset;
    logic                       load_en;
    logic [IMEM_AW-1:0]         load_addr;
    logic [`TINKER_INSTR_W-1:0] load_data;
    logic                       wb_valid;
    reg_addr_t                  wb_addr;
    logic [`TINKER_XLEN-1:0]    wb_data;
    logic                       hlt;

    // Program image and predicted trace of the current test
    logic [31:0] prog [$];
    logic [4:0]  exp_addr [$];
    logic [63:0] exp_data [$];
    longint      model_reg [32];
    longint      mem_model [longint];
    int          cycle_count = 0;

    tinker_core i_dut (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .hlt       (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ########################################
    // Failure handling and checks
    // ########################################
    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
            fail_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the core did not finish", cycle_count);
            fail_run();
        end
    end

    // Each strobe must match the next predicted write, in program order
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected write to r%0d at %0t ns", wb_addr, $time);
                fail_run();
            end else begin
                check_value("wb_addr", wb_addr, exp_addr.pop_front());
                check_value("wb_data", wb_data, exp_data.pop_front());
            end
        end
    end

    // ########################################
    // Program building and ISA model
    // ########################################
    function automatic logic [31:0] encode(input opcode_t op, input int rd, input int rs,
                                           input int rt, input int lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)};
    endfunction

    function automatic void emit(input opcode_t op, input int rd, input int rs,
                                 input int rt, input int lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
    endfunction

    function automatic longint sext12(input int lit);
        logic [11:0] low;
        low = 12'(lit);
        return {{52{low[11]}}, low};
    endfunction

    // MOV_LIT keeps the upper 52 bits of rd
    function automatic longint merge_low(input longint v, input int lit);
        return (v & 64'hffff_ffff_ffff_f000) | (sext12(lit) & 64'hfff);
    endfunction

    function automatic void predict(input int rd, input longint value);
        model_reg[rd] = value;
        exp_addr.push_back(5'(rd));
        exp_data.push_back(value);
    endfunction

    task automatic run_program();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        // Fill the rest with no-ops so older programs leave nothing behind
        while (prog.size() < PROG_WORDS) begin
            prog.push_back(encode(OP_PRIV, 0, 0, 0, 1));
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= IMEM_AW'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        reset   <= 1'b0;
        do @(negedge clk); while (hlt !== 1'b1);
        // Halt must hold with no further strobes
        repeat (20) begin
            @(negedge clk);
            check_value("hlt", hlt, 64'd1);
        end
        if (exp_addr.size() != 0) begin
            $display("Core halted with %0d predicted writes missing", exp_addr.size());
            fail_run();
        end
        prog.delete();
        mem_model.delete();
        foreach (model_reg[i]) begin
            model_reg[i] = 0;
        end
    endtask

    // ########################################
    // Directed tests
    // ########################################
    task automatic alu_chain();
        emit(OP_MOV_LIT, 1, 0, 0, 100);   predict(1, merge_low(model_reg[1], 100));
        emit(OP_MOV_LIT, 2, 0, 0, 7);     predict(2, merge_low(model_reg[2], 7));
        emit(OP_ADD, 3, 1, 2, 0);         predict(3, model_reg[1] + model_reg[2]);
        emit(OP_SUB, 4, 3, 1, 0);         predict(4, model_reg[3] - model_reg[1]);
        emit(OP_AND, 5, 4, 3, 0);         predict(5, model_reg[4] & model_reg[3]);
        emit(OP_OR, 6, 5, 4, 0);          predict(6, model_reg[5] | model_reg[4]);
        emit(OP_XOR, 7, 6, 3, 0);         predict(7, model_reg[6] ^ model_reg[3]);
        emit(OP_NOT, 8, 7, 0, 0);         predict(8, ~model_reg[7]);
        emit(OP_SHFTL, 9, 7, 2, 0);       predict(9, model_reg[7] << (model_reg[2] & 63));
        emit(OP_SHFTR, 10, 8, 2, 0);      predict(10, model_reg[8] >>> (model_reg[2] & 63));
        emit(OP_MOV_REG, 11, 10, 0, 0);   predict(11, model_reg[10]);
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program();
    endtask

    task automatic immediate_forms();
        emit(OP_MOV_LIT, 1, 0, 0, 40);    predict(1, merge_low(model_reg[1], 40));
        emit(OP_ADDI, 1, 0, 0, -50);      predict(1, model_reg[1] + sext12(-50));
        emit(OP_SUBI, 1, 0, 0, -3);       predict(1, model_reg[1] - sext12(-3));
        emit(OP_SHFTLI, 1, 0, 0, -60);    predict(1, model_reg[1] << (sext12(-60) & 63));
        emit(OP_SHFTRI, 1, 0, 0, -62);    predict(1, model_reg[1] >>> (sext12(-62) & 63));
        emit(OP_MOV_LIT, 1, 0, 0, 'h123); predict(1, merge_low(model_reg[1], 'h123));
        emit(OP_MOV_LIT, 2, 0, 0, -2);    predict(2, merge_low(model_reg[2], -2));
        emit(OP_ADDI, 2, 0, 0, -2048);    predict(2, model_reg[2] + sext12(-2048));
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program();
    endtask

    task automatic store_then_load();
        emit(OP_MOV_LIT, 1, 0, 0, 'h5a5); predict(1, merge_low(model_reg[1], 'h5a5));
        emit(OP_SHFTLI, 1, 0, 0, 20);     predict(1, model_reg[1] << 20);
        emit(OP_ADDI, 1, 0, 0, 60);       predict(1, model_reg[1] + 60);
        emit(OP_MOV_LIT, 2, 0, 0, 'h100); predict(2, merge_low(model_reg[2], 'h100));
        emit(OP_MOV_STR, 2, 1, 0, 8);
        mem_model[model_reg[2] + 8] = model_reg[1];
        emit(OP_MOV_MEM, 3, 2, 0, 8);     predict(3, mem_model[model_reg[2] + 8]);
        emit(OP_ADD, 4, 3, 1, 0);         predict(4, model_reg[3] + model_reg[1]);
        emit(OP_MOV_STR, 2, 4, 0, -16);
        mem_model[model_reg[2] - 16] = model_reg[4];
        emit(OP_MOV_MEM, 5, 2, 0, -16);   predict(5, mem_model[model_reg[2] - 16]);
        emit(OP_SUB, 6, 1, 5, 0);         predict(6, model_reg[1] - model_reg[5]);
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program();
    endtask

    // Word numbers in the comments are offsets from the reset PC
    task automatic branch_paths();
        emit(OP_MOV_LIT, 10, 0, 0, 'h200); predict(10, merge_low(model_reg[10], 'h200));
        emit(OP_SHFTLI, 10, 0, 0, 4);      predict(10, model_reg[10] << 4);
        emit(OP_ADDI, 10, 0, 0, 32);       predict(10, model_reg[10] + 32);
        emit(OP_BR, 10, 0, 0, 0);
        // Words 4 to 7 write r20 only if the redirect fails
        repeat (4) emit(OP_MOV_LIT, 20, 0, 0, 'hbad);
        emit(OP_MOV_LIT, 1, 0, 0, 16);     predict(1, merge_low(model_reg[1], 16));
        emit(OP_BRR, 1, 0, 0, 0);
        repeat (3) emit(OP_MOV_LIT, 20, 0, 0, 'hbad);
        // Word 13 jumps to word 16
        emit(OP_BRRI, 0, 0, 0, 12);
        repeat (2) emit(OP_MOV_LIT, 20, 0, 0, 'hbad);
        emit(OP_ADDI, 2, 0, 0, -1);        predict(2, model_reg[2] + sext12(-1));
        emit(OP_BRNZ, 10, 5, 0, 0);
        emit(OP_MOV_LIT, 3, 0, 0, 5);      predict(3, merge_low(model_reg[3], 5));
        emit(OP_ADDI, 10, 0, 0, 64);       predict(10, model_reg[10] + 64);
        emit(OP_BRNZ, 10, 3, 0, 0);
        repeat (3) emit(OP_MOV_LIT, 20, 0, 0, 'hbad);
        // Signed compare, so -1 is not above 5
        emit(OP_BRGT, 10, 2, 3, 0);
        emit(OP_ADDI, 10, 0, 0, 16);       predict(10, model_reg[10] + 16);
        emit(OP_BRGT, 10, 3, 2, 0);
        emit(OP_MOV_LIT, 20, 0, 0, 'hbad);
        emit(OP_MOV_LIT, 4, 0, 0, 'h77);   predict(4, merge_low(model_reg[4], 'h77));
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program();
    endtask

    task automatic halt_and_hold();
        emit(OP_MOV_LIT, 1, 0, 0, 9);     predict(1, merge_low(model_reg[1], 9));
        emit(OP_PRIV, 0, 0, 0, 5);
        emit(OP_ADDI, 1, 0, 0, 1);        predict(1, model_reg[1] + 1);
        emit(OP_PRIV, 0, 0, 0, 0);
        // None of these may reach the trace
        emit(OP_MOV_LIT, 2, 0, 0, 'h55);
        emit(OP_ADDI, 1, 0, 0, 1);
        emit(OP_MOV_LIT, 3, 0, 0, 1);
        run_program();
    endtask

    initial begin
        reset     <= 1'b1;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        alu_chain();
        immediate_forms();
        store_then_load();
        branch_paths();
        halt_and_hold();
        $display("TEST PASSED");
        $finish;
    end

endmodule
